// File: common/exu_pkg.sv
package exu_pkg;

    // --------------------
    // widths and sizes
    // --------------------

    // datapath width
    localparam int xlen = 32;

    // data memory depth in 32-bit words
    localparam int dmem_words = 256;

    // word address width into the data memory
    localparam int dmem_addr_bits = $clog2(dmem_words);

    // --------------------
    // encodings
    // --------------------

    // alu operand pairing, first operand listed first
    typedef enum logic [1:0] {
        src_imm_zero = 2'b00, // lui
        src_pc_imm   = 2'b01, // auipc, jal, jalr link path
        src_rs1_rs2  = 2'b10, // register-register ops and branches
        src_rs1_imm  = 2'b11  // register-immediate ops, load/store address
    } src_sel_e;

    // alu function, follows the funct3 layout
    typedef enum logic [2:0] {
        op_add  = 3'b000,
        op_sll  = 3'b001,
        op_slt  = 3'b010,
        op_sltu = 3'b011,
        op_xor  = 3'b100,
        op_shr  = 3'b101,
        op_or   = 3'b110,
        op_and  = 3'b111
    } alu_op_e;

    // memory access width
    typedef enum logic [1:0] {
        mem_none = 2'b00,
        mem_byte = 2'b01,
        mem_half = 2'b10,
        mem_word = 2'b11
    } mem_size_e;

    // --------------------
    // bundles
    // --------------------

    // decoded control word from the upstream decoder
    typedef struct packed {
        src_sel_e  src_sel;
        alu_op_e   alu_op;
        logic      sub;         // subtract on op_add
        logic      arith;       // arithmetic right shift on op_shr
        logic      negate;      // invert compare result
        logic      link;        // result is var1 + 4
        mem_size_e mem_size;
        logic      mem_write;   // store when set, load otherwise
        logic      load_signed;
        logic      is_ebreak;
    } exu_ctrl_t;

    // register operands, immediate and pc
    typedef struct packed {
        logic [xlen-1:0] rs1_d;
        logic [xlen-1:0] rs2_d;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } exu_operands_t;

    // registered results
    typedef struct packed {
        logic [xlen-1:0] rd_data;
        logic [xlen-1:0] csr_wdata;
    } exu_result_t;

    // data memory request, word addressed
    typedef struct packed {
        logic [dmem_addr_bits-1:0] addr;
        logic [xlen-1:0]           wdata;
        logic [3:0]                wmask;  // one bit per byte lane
        logic                      we;
    } mem_req_t;

endpackage

// File: alu/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [exu_pkg::xlen-1:0] var1,
    input  logic [exu_pkg::xlen-1:0] var2,
    input  exu_pkg::alu_op_e         op,
    input  logic                     sub,
    input  logic                     arith,
    input  logic                     negate,
    input  logic                     link,
    output logic [exu_pkg::xlen-1:0] res
);
    import exu_pkg::*;

    // --------------------
    // shared terms
    // --------------------

    // shift amount from the low five bits only
    logic [4:0] shamt;
    assign shamt = var2[4:0];

    // add or subtract
    logic [xlen-1:0] sum;
    assign sum = sub ? (var1 - var2) : (var1 + var2);

    // compare results before optional inversion
    logic lt_signed;
    logic lt_unsigned;
    assign lt_signed   = $signed(var1) < $signed(var2);
    assign lt_unsigned = var1 < var2;

    // right shift, logical or arithmetic
    logic [xlen-1:0] shr;
    assign shr = arith ? xlen'($signed(var1) >>> shamt) : (var1 >> shamt);

    // --------------------
    // result select
    // --------------------

    always_comb begin
        res = '0;
        if (link) begin
            // return address for jal/jalr
            res = var1 + xlen'(4);
        end else begin
            case (op)
                op_add: begin
                    res = sum;
                end
                op_sll: begin
                    res = var1 << shamt;
                end
                op_slt: begin
                    // negate turns blt into bge
                    res = {{(xlen-1){1'b0}}, lt_signed ^ negate};
                end
                op_sltu: begin
                    res = {{(xlen-1){1'b0}}, lt_unsigned ^ negate};
                end
                op_xor: begin
                    res = var1 ^ var2;
                end
                op_shr: begin
                    res = shr;
                end
                op_or: begin
                    res = var1 | var2;
                end
                op_and: begin
                    res = var1 & var2;
                end
                default: begin
                    res = '0;
                end
            endcase
        end
    end

endmodule

// File: exu/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  exu_pkg::exu_ctrl_t       ctrl,
    input  logic [exu_pkg::xlen-1:0] addr,
    input  logic [exu_pkg::xlen-1:0] rs2_d,
    input  logic [exu_pkg::xlen-1:0] alu_res,
    input  logic                     valid,
    output exu_pkg::mem_req_t        mem_req,
    input  logic [exu_pkg::xlen-1:0] mem_rdata,
    output logic [exu_pkg::xlen-1:0] rd_data
);
    import exu_pkg::*;

    // byte offset inside the word and the matching bit shift
    logic [1:0] offset;
    logic [4:0] lane_shift;
    assign offset     = addr[1:0];
    assign lane_shift = {offset, 3'b000};

    logic is_mem;
    logic is_store;
    assign is_mem   = ctrl.mem_size != mem_none;
    assign is_store = is_mem && ctrl.mem_write;

    // --------------------
    // store path
    // --------------------

    logic [3:0] lane_mask;

    always_comb begin
        case (ctrl.mem_size)
            mem_byte: lane_mask = 4'b0001 << offset;
            // address bit 1 picks the upper half
            mem_half: lane_mask = offset[1] ? 4'b1100 : 4'b0011;
            mem_word: lane_mask = 4'b1111;
            default:  lane_mask = 4'b0000;
        endcase
    end

    always_comb begin
        mem_req.addr  = addr[dmem_addr_bits+1:2];
        // data lands in the addressed lanes
        mem_req.wdata = rs2_d << lane_shift;
        mem_req.wmask = lane_mask;
        // write only in a valid cycle
        mem_req.we    = valid && is_store;
    end

    // --------------------
    // load path
    // --------------------

    // addressed lane moved down to bit 0
    logic [xlen-1:0] load_word;
    assign load_word = mem_rdata >> lane_shift;

    always_comb begin
        if (!is_mem) begin
            // plain alu op, no memory access
            rd_data = alu_res;
        end else if (is_store) begin
            rd_data = '0;
        end else begin
            case (ctrl.mem_size)
                mem_byte: begin
                    rd_data = {{(xlen-8){load_word[7] & ctrl.load_signed}}, load_word[7:0]};
                end
                mem_half: begin
                    rd_data = {{(xlen-16){load_word[15] & ctrl.load_signed}}, load_word[15:0]};
                end
                default: begin
                    rd_data = load_word;
                end
            endcase
        end
    end

endmodule

// File: exu/exu.sv
`timescale 1ns/1ps

module exu (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  exu_pkg::exu_ctrl_t       ctrl,
    input  exu_pkg::exu_operands_t   ops,
    output exu_pkg::mem_req_t        mem_req,
    input  logic [exu_pkg::xlen-1:0] mem_rdata,
    output logic                     out_valid,
    output exu_pkg::exu_result_t     result,
    output logic                     halt,
    output logic [exu_pkg::xlen-1:0] halt_code
);
    import exu_pkg::*;

    // --------------------
    // operand select
    // --------------------

    logic [xlen-1:0] var1;
    logic [xlen-1:0] var2;

    always_comb begin
        case (ctrl.src_sel)
            src_imm_zero: begin
                var1 = ops.imm;
                var2 = '0;
            end
            src_pc_imm: begin
                var1 = ops.pc;
                var2 = ops.imm;
            end
            src_rs1_rs2: begin
                var1 = ops.rs1_d;
                var2 = ops.rs2_d;
            end
            default: begin
                var1 = ops.rs1_d;
                var2 = ops.imm;
            end
        endcase
    end

    // --------------------
    // alu and load/store
    // --------------------

    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] lsu_rd;

    alu u_alu (
        .var1   (var1),
        .var2   (var2),
        .op     (ctrl.alu_op),
        .sub    (ctrl.sub),
        .arith  (ctrl.arith),
        .negate (ctrl.negate),
        .link   (ctrl.link),
        .res    (alu_res)
    );

    // alu result doubles as the byte address
    lsu u_lsu (
        .ctrl      (ctrl),
        .addr      (alu_res),
        .rs2_d     (ops.rs2_d),
        .alu_res   (alu_res),
        .valid     (valid),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .rd_data   (lsu_rd)
    );

    // --------------------
    // output register
    // --------------------

    // strobes, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            halt      <= 1'b0;
        end else begin
            out_valid <= valid;
            // one pulse per ebreak result
            halt      <= valid && ctrl.is_ebreak;
        end
    end

    // payload holds between valids
    always_ff @(posedge clk) begin
        if (valid) begin
            result.rd_data   <= lsu_rd;
            // csr write value is rs2 as is
            result.csr_wdata <= ops.rs2_d;
            // exit code for ebreak
            halt_code        <= ops.rs1_d;
        end
    end

endmodule

// File: hw/dmem.sv
`timescale 1ns/1ps

module dmem (
    input  logic                     clk,
    input  exu_pkg::mem_req_t        mem_req,
    output logic [exu_pkg::xlen-1:0] rdata
);
    import exu_pkg::*;

    // word storage
    logic [xlen-1:0] mem [dmem_words];

    // start from all zeros in simulation
    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            mem[i] = '0;
        end
    end

    // --------------------
    // write port
    // --------------------

    // byte lanes gated by wmask
    always @(posedge clk) begin
        if (mem_req.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (mem_req.wmask[lane]) begin
                    mem[mem_req.addr][lane*8 +: 8] <= mem_req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // combinational read
    assign rdata = mem[mem_req.addr];

endmodule

// File: hw/exu_top.sv
`timescale 1ns/1ps

module exu_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  exu_pkg::exu_ctrl_t       ctrl,
    input  exu_pkg::exu_operands_t   ops,
    output logic                     out_valid,
    output exu_pkg::exu_result_t     result,
    output logic                     halt,
    output logic [exu_pkg::xlen-1:0] halt_code
);
    import exu_pkg::*;

    // --------------------
    // internal wires
    // --------------------

    // request from exu into the data memory
    mem_req_t        mem_req;
    // same-cycle read word back to exu
    logic [xlen-1:0] mem_rdata;

    // --------------------
    // execute stage
    // --------------------

    exu u_exu (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .ctrl      (ctrl),
        .ops       (ops),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .out_valid (out_valid),
        .result    (result),
        .halt      (halt),
        .halt_code (halt_code)
    );

    // data memory, byte-masked writes
    dmem u_dmem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

endmodule

// File: tests/exu_checker.sv
`timescale 1ns/1ps

module exu_checker (
    input logic clk,
    input logic reset,
    input logic valid,
    input logic out_valid,
    input logic halt
);

    // failed assertion count, read by the testbench at the end
    int failures = 0;

    // --------------------
    // strobe properties
    // --------------------

    // a reset cycle leaves both strobes low
    a_reset_quiet: assert property (@(posedge clk) reset |=> (!out_valid && !halt))
        else begin
            failures++;
            $error("out_valid or halt high after a reset cycle");
        end

    // halt only rides on a result
    a_halt_with_valid: assert property (@(posedge clk) disable iff (reset) halt |-> out_valid)
        else begin
            failures++;
            $error("halt high without out_valid");
        end

    // one cycle latency, no gaps or extras
    a_valid_follow: assert property (@(posedge clk) !reset |=> (out_valid == $past(valid)))
        else begin
            failures++;
            $error("out_valid does not follow valid by one cycle");
        end

endmodule

bind exu_top exu_checker u_exu_checker (
    .clk       (clk),
    .reset     (reset),
    .valid     (valid),
    .out_valid (out_valid),
    .halt      (halt)
);

// File: tests/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int    reset_cycles = 8;
    localparam int    max_cases    = 64;
    // idle gap after every few cases
    localparam int    idle_every   = 4;
    localparam int    idle_len     = 2;
    localparam string case_file    = "tests/exu_cases.txt";

    // --------------------
    // DUT signals
    // --------------------

    logic            clk;
    logic            reset;
    logic            valid;
    exu_ctrl_t       ctrl;
    exu_operands_t   ops;
    logic            out_valid;
    exu_result_t     result;
    logic            halt;
    logic [xlen-1:0] halt_code;

    // case table from the file
    string           case_name [max_cases];
    exu_ctrl_t       case_ctrl [max_cases];
    exu_operands_t   case_ops  [max_cases];
    logic [xlen-1:0] exp_rd    [max_cases];
    logic [xlen-1:0] exp_csr   [max_cases];
    logic            exp_halt  [max_cases];
    logic [xlen-1:0] exp_code  [max_cases];

    int num_cases   = 0;
    int error_count = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    exu_top u_exu_top (
        .clk       (clk),
        .reset     (reset),
        .valid     (valid),
        .ctrl      (ctrl),
        .ops       (ops),
        .out_valid (out_valid),
        .result    (result),
        .halt      (halt),
        .halt_code (halt_code)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // --------------------
    // helpers
    // --------------------

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %0s %0s: expected %08h, actual %08h",
                     test, field, expected, actual);
            error_count++;
        end
    endtask

    // one line per finished test
    task automatic report_test(input string test, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %-12s pass", test);
        end else begin
            fail_count++;
            $display("test %-12s FAIL", test);
        end
    endtask

    task automatic load_cases(output int count);
        int          fd;
        int          fields;
        string       line;
        string       name;
        // columns after the name
        // 0 src, 1 op, 2 sub, 3 ari, 4 neg, 5 lnk, 6 msz, 7 mwr, 8 lsg, 9 ebk
        // 10 rs1, 11 rs2, 12 imm, 13 pc, 14 rd, 15 csr, 16 halt, 17 code
        logic [31:0] col [18];
        count = 0;
        fd = $fopen(case_file, "r");
        if (fd != 0) begin
            while (!$feof(fd) && count < max_cases) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(
                        line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, col[0], col[1], col[2], col[3], col[4], col[5],
                        col[6], col[7], col[8], col[9], col[10], col[11],
                        col[12], col[13], col[14], col[15], col[16], col[17]);
                    // short lines are skipped
                    if (fields == 19) begin
                        case_name[count]             = name;
                        case_ctrl[count].src_sel     = src_sel_e'(col[0][1:0]);
                        case_ctrl[count].alu_op      = alu_op_e'(col[1][2:0]);
                        case_ctrl[count].sub         = col[2][0];
                        case_ctrl[count].arith       = col[3][0];
                        case_ctrl[count].negate      = col[4][0];
                        case_ctrl[count].link        = col[5][0];
                        case_ctrl[count].mem_size    = mem_size_e'(col[6][1:0]);
                        case_ctrl[count].mem_write   = col[7][0];
                        case_ctrl[count].load_signed = col[8][0];
                        case_ctrl[count].is_ebreak   = col[9][0];
                        case_ops[count].rs1_d        = col[10];
                        case_ops[count].rs2_d        = col[11];
                        case_ops[count].imm          = col[12];
                        case_ops[count].pc           = col[13];
                        exp_rd[count]                = col[14];
                        exp_csr[count]               = col[15];
                        exp_halt[count]              = col[16][0];
                        exp_code[count]              = col[17];
                        count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // result of the case driven one edge earlier
    task automatic check_case(input int idx);
        int errors_before;
        errors_before = error_count;
        check_value(case_name[idx], "out_valid", 32'd1, {31'd0, out_valid});
        check_value(case_name[idx], "rd_data", exp_rd[idx], result.rd_data);
        check_value(case_name[idx], "csr_wdata", exp_csr[idx], result.csr_wdata);
        check_value(case_name[idx], "halt", {31'd0, exp_halt[idx]}, {31'd0, halt});
        // exit code only defined with halt
        if (exp_halt[idx]) begin
            check_value(case_name[idx], "halt_code", exp_code[idx], halt_code);
        end
        report_test(case_name[idx], errors_before);
    endtask

    // idle window, strobes stay low
    task automatic run_idle(input string test, input int cycles);
        int errors_before;
        errors_before = error_count;
        valid = 1'b0;
        ctrl  = '0;
        ops   = '0;
        for (int k = 0; k < cycles; k++) begin
            @(posedge clk);
            #1;
            check_value(test, "out_valid", 32'd0, {31'd0, out_valid});
            check_value(test, "halt", 32'd0, {31'd0, halt});
        end
        report_test(test, errors_before);
    endtask

    // --------------------
    // timeout
    // --------------------

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    // --------------------
    // main sequence
    // --------------------

    initial begin
        int n;
        int errors_before;
        int checker_failures;
        reset = 1'b1;
        valid = 1'b0;
        ctrl  = '0;
        ops   = '0;
        load_cases(n);
        num_cases = n;
        if (num_cases == 0) begin
            $display("no test cases could be read from %0s", case_file);
            $display("Done: errors found");
            $finish;
        end else begin
            // cases, idle gaps, reset and some slack
            cycle_limit = num_cases + (num_cases / idle_every + 1) * idle_len
                          + reset_cycles + 50;

            // strobes low during reset
            errors_before = error_count;
            for (int c = 0; c < reset_cycles; c++) begin
                @(posedge clk);
                #1;
                check_value("reset", "out_valid", 32'd0, {31'd0, out_valid});
                check_value("reset", "halt", 32'd0, {31'd0, halt});
            end
            report_test("reset", errors_before);
            reset = 1'b0;

            for (int i = 0; i < num_cases; i++) begin
                // drive 1 ns after the edge
                valid = 1'b1;
                ctrl  = case_ctrl[i];
                ops   = case_ops[i];
                @(posedge clk);
                #1;
                check_case(i);
                if (i % idle_every == idle_every - 1) begin
                    run_idle($sformatf("idle_%0d", i), idle_len);
                end
            end
            run_idle("idle_end", idle_len);

            checker_failures = u_exu_top.u_exu_checker.failures;
            $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                     pass_count + fail_count, pass_count, fail_count, checker_failures);
            if (error_count == 0 && checker_failures == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

// File: tests/exu_cases.txt
# name src op sub ari neg lnk msz mwr lsg ebk rs1 rs2 imm pc rd csr halt code
# hex fields; src 0 imm/0 1 pc/imm 2 rs1/rs2 3 rs1/imm; msz 0 none 1 byte 2 half 3 word
add_rr     2 0 0 0 0 0 0 0 0 0 00000005 00000007 00000000 00000000 0000000c 00000007 0 00000000
sub_rr     2 0 1 0 0 0 0 0 0 0 00000005 00000007 00000000 00000000 fffffffe 00000007 0 00000000
xor_rr     2 4 0 0 0 0 0 0 0 0 f0f0f0f0 0ff00ff0 00000000 00000000 ff00ff00 0ff00ff0 0 00000000
or_ri      3 6 0 0 0 0 0 0 0 0 12340000 deadbeef 00005678 00000000 12345678 deadbeef 0 00000000
and_ri     3 7 0 0 0 0 0 0 0 0 ffff00ff 00000000 0f0f0f0f 00000000 0f0f000f 00000000 0 00000000
sll_rr     2 1 0 0 0 0 0 0 0 0 00000001 00000024 00000000 00000000 00000010 00000024 0 00000000
srl_rr     2 5 0 0 0 0 0 0 0 0 80000000 0000001f 00000000 00000000 00000001 0000001f 0 00000000
sra_ri     3 5 0 1 0 0 0 0 0 0 80000000 00000000 00000024 00000000 f8000000 00000000 0 00000000
slt_neg    2 2 0 0 0 0 0 0 0 0 ffffffff 00000001 00000000 00000000 00000001 00000001 0 00000000
sltu_top   2 3 0 0 0 0 0 0 0 0 ffffffff 00000001 00000000 00000000 00000000 00000001 0 00000000
bge_inv    2 2 0 0 1 0 0 0 0 0 ffffffff 00000001 00000000 00000000 00000000 00000001 0 00000000
bgeu_inv   2 3 0 0 1 0 0 0 0 0 ffffffff 00000001 00000000 00000000 00000001 00000001 0 00000000
lui        0 0 0 0 0 0 0 0 0 0 00000011 00000022 abcde000 00000000 abcde000 00000022 0 00000000
auipc      1 0 0 0 0 0 0 0 0 0 00000000 00000033 00002000 00001000 00003000 00000033 0 00000000
jal_link   1 0 0 0 0 1 0 0 0 0 00000000 00000000 00000040 00000100 00000104 00000000 0 00000000
sw_0       3 0 0 0 0 0 3 1 0 0 00000040 11223344 00000000 00000000 00000000 11223344 0 00000000
sb_1       3 0 0 0 0 0 1 1 0 0 00000040 000000aa 00000001 00000000 00000000 000000aa 0 00000000
sh_2       3 0 0 0 0 0 2 1 0 0 00000040 0000beef 00000002 00000000 00000000 0000beef 0 00000000
sb_3       3 0 0 0 0 0 1 1 0 0 00000040 00000080 00000003 00000000 00000000 00000080 0 00000000
sb_0       3 0 0 0 0 0 1 1 0 0 00000040 000000ff 00000000 00000000 00000000 000000ff 0 00000000
sh_0       3 0 0 0 0 0 2 1 0 0 00000044 ffff1234 00000000 00000000 00000000 ffff1234 0 00000000
lw_0       3 0 0 0 0 0 3 0 0 0 00000040 55555555 00000000 00000000 80efaaff 55555555 0 00000000
lb_s_1     3 0 0 0 0 0 1 0 1 0 00000040 00000000 00000001 00000000 ffffffaa 00000000 0 00000000
lbu_1      3 0 0 0 0 0 1 0 0 0 00000040 00000000 00000001 00000000 000000aa 00000000 0 00000000
lh_s_2     3 0 0 0 0 0 2 0 1 0 00000040 00000000 00000002 00000000 ffff80ef 00000000 0 00000000
lhu_0      3 0 0 0 0 0 2 0 0 0 00000040 00000000 00000000 00000000 0000aaff 00000000 0 00000000
lb_s_0     3 0 0 0 0 0 1 0 1 0 00000040 00000000 00000000 00000000 ffffffff 00000000 0 00000000
lbu_3      3 0 0 0 0 0 1 0 0 0 00000040 00000000 00000003 00000000 00000080 00000000 0 00000000
lw_44      3 0 0 0 0 0 3 0 0 0 00000044 00000000 00000000 00000000 00001234 00000000 0 00000000
ebreak     2 0 0 0 0 0 0 0 0 1 0000002a 00000000 00000000 00000000 0000002a 00000000 1 0000002a
after_halt 2 0 0 0 0 0 0 0 0 0 00000001 00000001 00000000 00000000 00000002 00000001 0 00000000

// File: build.f
common/exu_pkg.sv
alu/alu.sv
exu/lsu.sv
exu/exu.sv
hw/dmem.sv
hw/exu_top.sv
tests/exu_checker.sv
tests/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - common/exu_pkg.sv
  - alu/alu.sv
  - exu/lsu.sv
  - exu/exu.sv
  - hw/dmem.sv
  - hw/exu_top.sv
  - target: test
    files:
      - tests/exu_checker.sv
      - tests/exu_tb.sv
